/* build.f */
+incdir+include
rtl/cpu_pkg.sv
rtl/instr_decode.sv
rtl/alu.sv
rtl/register_file.sv
rtl/exec_sequencer.sv
rtl/cpu_top.sv
test/tb_ram.sv
test/cpu_tb.sv

/* Makefile */
# Verilator build of the CPU testbench

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module cpu_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vcpu_tb

clean:
	rm -rf $(OBJ_DIR)

/* test/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb
    import cpu_pkg::*;
();

    logic       clk;
    logic       reset_n;
    logic       int_req;
    logic       int_ack;
    logic       rd_ram_en;
    logic [7:0] rd_ram_addr;
    logic [7:0] rd_ram_data;
    logic       wr_ram_en;
    logic [7:0] wr_ram_addr;
    logic [7:0] wr_ram_data;

    logic [15:0] exp_q[$];
    logic [7:0]  asm_pc;
    int          instr_count;
    int          total_stores;
    int          store_count;
    int          ack_count;
    int          cycle;
    logic        program_ready;
    logic        cli_seen;
    logic        first_read_seen;

    cpu_top cpu_top_i (
        .clk(clk), .reset_n(reset_n),
        .rd_ram_en(rd_ram_en), .rd_ram_addr(rd_ram_addr), .rd_ram_data(rd_ram_data),
        .wr_ram_en(wr_ram_en), .wr_ram_addr(wr_ram_addr), .wr_ram_data(wr_ram_data),
        .int_req(int_req), .int_ack(int_ack)
    );

    tb_ram ram_i (
        .clk(clk),
        .rd_ram_en(rd_ram_en), .rd_ram_addr(rd_ram_addr), .rd_ram_data(rd_ram_data),
        .wr_ram_en(wr_ram_en), .wr_ram_addr(wr_ram_addr), .wr_ram_data(wr_ram_data)
    );

    always #5 clk = ~clk;

    task automatic fail_with(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (expected === actual) else
            fail_with($sformatf("CHECK FAILED %s: expected %h actual %h",
                                name, expected, actual));
    endtask

    task automatic emit_imm(input opcode_e op, input logic [3:0] rd, input logic [7:0] imm);
        ram_i.mem[asm_pc] = {op, rd};
        ram_i.mem[asm_pc + 8'd1] = imm;
        asm_pc = asm_pc + 8'd2;
        instr_count++;
    endtask

    task automatic emit_reg(input opcode_e op, input logic [3:0] rd,
                            input logic [3:0] ra, input logic [3:0] rb);
        emit_imm(op, rd, {ra, rb});
    endtask

    task automatic expect_store(input logic [7:0] addr, input logic [7:0] data);
        exp_q.push_back({addr, data});
        total_stores++;
    endtask

    task automatic assemble_program();
        logic [7:0] a, b, c, d, e, n, k, marker, loop_pc, skip_pc;
        logic [7:0] data [16];
        for (int i = 0; i < 256; i++) begin
            ram_i.mem[i] = 8'(i) ^ 8'hA5;
        end
        for (int i = 0; i < 16; i++) begin
            data[i] = 8'($urandom);
            ram_i.mem[8'h80 + 8'(i)] = data[i];
        end
        a = 8'($urandom);
        b = 8'($urandom);
        c = 8'($urandom);
        d = 8'($urandom);
        e = 8'($urandom);
        marker = 8'($urandom);
        k = 8'($urandom % 16);
        n = 8'($urandom % 4) + 8'd1;
        // Service routine
        asm_pc = `ISR_ADDRESS;
        emit_imm(MOVI, 4'd15, marker);
        emit_imm(STORE, 4'd15, 8'h9F);
        emit_imm(RETI, 4'd0, 8'h00);
        // Main program from address 0
        asm_pc = 8'h00;
        emit_imm(MOVI, 4'd1, a);
        emit_imm(MOVI, 4'd2, b);
        emit_imm(STORE, 4'd1, 8'h90);
        expect_store(8'h90, a);
        emit_reg(ADD, 4'd3, 4'd1, 4'd2);
        emit_imm(STORE, 4'd3, 8'h91);
        expect_store(8'h91, a + b);
        emit_reg(SUB, 4'd4, 4'd1, 4'd2);
        emit_imm(STORE, 4'd4, 8'h92);
        expect_store(8'h92, a - b);
        emit_imm(ADDI, 4'd1, c);
        emit_imm(STORE, 4'd1, 8'h93);
        expect_store(8'h93, a + c);
        emit_imm(SUBI, 4'd2, d);
        emit_imm(STORE, 4'd2, 8'h94);
        expect_store(8'h94, b - d);
        emit_imm(LOAD, 4'd5, 8'h80 + k);
        emit_imm(STORE, 4'd5, 8'h95);
        expect_store(8'h95, data[k]);
        // Countdown loop
        emit_imm(MOVI, 4'd6, n);
        loop_pc = asm_pc;
        emit_imm(SUBI, 4'd6, 8'd1);
        emit_imm(STORE, 4'd6, 8'hA0);
        emit_imm(JNZ, 4'd0, loop_pc);
        for (int i = int'(n) - 1; i >= 0; i--) begin
            expect_store(8'hA0, 8'(i));
        end
        skip_pc = asm_pc + 8'd4;
        emit_imm(JMP, 4'd0, skip_pc);
        emit_imm(STORE, 4'd6, 8'hA8);
        // Interrupt is raised once the 0x96 store is seen
        emit_imm(STI, 4'd0, 8'h00);
        emit_imm(STORE, 4'd3, 8'h96);
        expect_store(8'h96, a + b);
        expect_store(8'h9F, marker);
        emit_imm(NOP, 4'd0, 8'h00);
        emit_imm(NOP, 4'd0, 8'h00);
        emit_imm(NOP, 4'd0, 8'h00);
        emit_imm(STORE, 4'd4, 8'h97);
        expect_store(8'h97, a - b);
        emit_imm(MOVI, 4'd7, e);
        emit_imm(STORE, 4'd7, 8'h98);
        expect_store(8'h98, e);
        emit_imm(CLI, 4'd0, 8'h00);
        emit_imm(STORE, 4'd1, 8'h99);
        expect_store(8'h99, a + c);
        emit_imm(NOP, 4'd0, 8'h00);
        emit_imm(NOP, 4'd0, 8'h00);
        emit_imm(NOP, 4'd0, 8'h00);
        emit_imm(STORE, 4'd2, 8'h9A);
        expect_store(8'h9A, b - d);
        emit_imm(JMP, 4'd0, asm_pc);
    endtask

    // Store scoreboard and port checks
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!reset_n && cycle > 0) begin
            check_value("reset outputs", 8'h00, {5'b0, rd_ram_en, wr_ram_en, int_ack});
        end
        if (reset_n && rd_ram_en && !first_read_seen) begin
            check_value("first read address", 8'h00, rd_ram_addr);
            first_read_seen <= 1'b1;
        end
        if (reset_n && wr_ram_en) begin
            assert (exp_q.size() != 0) else
                fail_with($sformatf("Unexpected store of %h to address %h",
                                    wr_ram_data, wr_ram_addr));
            check_value("store address", exp_q[0][15:8], wr_ram_addr);
            check_value($sformatf("store data at %h", wr_ram_addr),
                        exp_q[0][7:0], wr_ram_data);
            void'(exp_q.pop_front());
            store_count <= store_count + 1;
        end
        if (reset_n && int_ack) begin
            assert (!cli_seen) else
                fail_with("Interrupt acknowledged while interrupts were disabled");
            check_value("service fetch address", `ISR_ADDRESS, rd_ram_addr);
            check_value("service fetch enable", 8'h01, {7'b0, rd_ram_en});
            ack_count <= ack_count + 1;
        end
    end

    // A load's data read is followed by its write-back, not by another read
    assert property (@(posedge clk) disable iff (!reset_n)
        (rd_ram_en && rd_ram_addr[7:4] == 4'h8) |=> !rd_ram_en)
        else fail_with("A read was issued between the load data read and its write-back");

    // Interrupt stimulus
    initial begin
        wait (program_ready);
        do @(posedge clk); while (!(wr_ram_en && wr_ram_addr == 8'h96));
        @(negedge clk);
        int_req = 1'b1;
        do @(posedge clk); while (!int_ack);
        @(negedge clk);
        int_req = 1'b0;
        do @(posedge clk); while (!(wr_ram_en && wr_ram_addr == 8'h99));
        cli_seen = 1'b1;
        @(negedge clk);
        int_req = 1'b1;
        repeat (4) @(negedge clk);
        int_req = 1'b0;
    end

    // Watchdog
    initial begin
        wait (program_ready);
        repeat (10 + instr_count * 2 * 5 + 40) @(posedge clk);
        fail_with("Timeout: the program did not finish its stores in time");
    end

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        int_req = 1'b0;
        cycle = 0;
        instr_count = 0;
        total_stores = 0;
        store_count = 0;
        ack_count = 0;
        cli_seen = 1'b0;
        first_read_seen = 1'b0;
        program_ready = 1'b0;
        void'($urandom(32'hf059));
        assemble_program();
        program_ready = 1'b1;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        while (store_count != total_stores) @(posedge clk);
        repeat (30) @(posedge clk);
        if (ack_count == 1) begin
            $display("Verification passed");
            $finish;
        end else begin
            fail_with($sformatf("CHECK FAILED interrupt count: expected %0d actual %0d",
                                1, ack_count));
        end
    end

endmodule

`default_nettype wire

/* test/tb_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module tb_ram (
    input  wire                   clk,
    input  wire                   rd_ram_en,
    input  wire [`ADDR_BITS-1:0]  rd_ram_addr,
    output logic [`DATA_BITS-1:0] rd_ram_data,
    input  wire                   wr_ram_en,
    input  wire [`ADDR_BITS-1:0]  wr_ram_addr,
    input  wire [`DATA_BITS-1:0]  wr_ram_data
);

    // Contents are loaded by the testbench before reset
    logic [`DATA_BITS-1:0] mem [2**`ADDR_BITS];

    // Read data shows up one cycle after the enable
    always_ff @(posedge clk) begin
        if (rd_ram_en) begin
            rd_ram_data <= mem[rd_ram_addr];
        end
    end

    always @(posedge clk) begin
        if (wr_ram_en) begin
            mem[wr_ram_addr] <= wr_ram_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset_n,
    output logic                  rd_ram_en,
    output logic [`ADDR_BITS-1:0] rd_ram_addr,
    input  wire [`DATA_BITS-1:0]  rd_ram_data,
    output logic                  wr_ram_en,
    output logic [`ADDR_BITS-1:0] wr_ram_addr,
    output logic [`DATA_BITS-1:0] wr_ram_data,
    input  wire                   int_req,
    output logic                  int_ack
);

    instr_word_t                ir;
    alu_op_e                    alu_op;
    wb_src_e                    wb_src;
    logic                       b_imm;
    logic                       writes_reg;
    logic                       is_load;
    logic                       is_store;
    logic                       is_jnz;
    logic                       is_jmp;
    logic                       is_cli;
    logic                       is_sti;
    logic                       is_reti;
    logic [`REG_ADDR_BITS-1:0]  rd_a_addr;
    logic [`REG_ADDR_BITS-1:0]  rd_b_addr;
    logic [`DATA_BITS-1:0]      rd_a_data;
    logic [`DATA_BITS-1:0]      rd_b_data;
    logic [`DATA_BITS-1:0]      alu_b;
    logic [`DATA_BITS-1:0]      alu_result;
    logic                       alu_zero;
    logic                       reg_wr_en;
    logic [`REG_ADDR_BITS-1:0]  reg_wr_addr;
    logic [`DATA_BITS-1:0]      reg_wr_data;

    exec_sequencer exec_sequencer_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_ram_en   (rd_ram_en),
        .rd_ram_addr (rd_ram_addr),
        .rd_ram_data (rd_ram_data),
        .wr_ram_en   (wr_ram_en),
        .wr_ram_addr (wr_ram_addr),
        .wr_ram_data (wr_ram_data),
        .int_req     (int_req),
        .int_ack     (int_ack),
        .ir          (ir),
        .b_imm       (b_imm),
        .writes_reg  (writes_reg),
        .wb_src      (wb_src),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_jnz      (is_jnz),
        .is_jmp      (is_jmp),
        .is_cli      (is_cli),
        .is_sti      (is_sti),
        .is_reti     (is_reti),
        .alu_result  (alu_result),
        .alu_zero    (alu_zero),
        .alu_b       (alu_b),
        .rd_a_data   (rd_a_data),
        .rd_b_data   (rd_b_data),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data)
    );

    instr_decode instr_decode_i (
        .ir         (ir),
        .alu_op     (alu_op),
        .b_imm      (b_imm),
        .writes_reg (writes_reg),
        .wb_src     (wb_src),
        .is_load    (is_load),
        .is_store   (is_store),
        .is_jnz     (is_jnz),
        .is_jmp     (is_jmp),
        .is_cli     (is_cli),
        .is_sti     (is_sti),
        .is_reti    (is_reti),
        .rd_a_addr  (rd_a_addr),
        .rd_b_addr  (rd_b_addr)
    );

    alu alu_i (
        .a      (rd_a_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    register_file register_file_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .rd_a_addr (rd_a_addr),
        .rd_b_addr (rd_b_addr),
        .wr_en     (reg_wr_en),
        .wr_addr   (reg_wr_addr),
        .wr_data   (reg_wr_data),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data)
    );

endmodule

`default_nettype wire

/* rtl/exec_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module exec_sequencer
    import cpu_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset_n,
    output logic                        rd_ram_en,
    output logic [`ADDR_BITS-1:0]       rd_ram_addr,
    input  wire [`DATA_BITS-1:0]        rd_ram_data,
    output logic                        wr_ram_en,
    output logic [`ADDR_BITS-1:0]       wr_ram_addr,
    output logic [`DATA_BITS-1:0]       wr_ram_data,
    input  wire                         int_req,
    output logic                        int_ack,
    output instr_word_t                 ir,
    input  wire                         b_imm,
    input  wire                         writes_reg,
    input  wire wb_src_e                wb_src,
    input  wire                         is_load,
    input  wire                         is_store,
    input  wire                         is_jnz,
    input  wire                         is_jmp,
    input  wire                         is_cli,
    input  wire                         is_sti,
    input  wire                         is_reti,
    input  wire [`DATA_BITS-1:0]        alu_result,
    input  wire                         alu_zero,
    output logic [`DATA_BITS-1:0]       alu_b,
    input  wire [`DATA_BITS-1:0]        rd_a_data,
    input  wire [`DATA_BITS-1:0]        rd_b_data,
    output logic                        reg_wr_en,
    output logic [`REG_ADDR_BITS-1:0]   reg_wr_addr,
    output logic [`DATA_BITS-1:0]       reg_wr_data
);

    localparam logic [2:0] IDLE      = 3'd0;
    localparam logic [2:0] FETCH_HI  = 3'd1;
    localparam logic [2:0] FETCH_LO  = 3'd2;
    localparam logic [2:0] EXECUTE   = 3'd3;
    localparam logic [2:0] WRITEBACK = 3'd4;

    logic [2:0]            state;
    logic [`ADDR_BITS-1:0] pc;
    logic [`ADDR_BITS-1:0] next_pc;
    logic [`ADDR_BITS-1:0] fetch_pc;
    logic [`ADDR_BITS-1:0] saved_pc;
    logic [`DATA_BITS-1:0] alu_res;
    logic                  zero_flag;
    logic                  int_en;
    logic                  int_pend;
    logic                  int_req_q;
    logic                  int_edge;
    logic                  is_arith;
    logic                  needs_wb;
    logic                  issue_fetch;
    logic                  take_int;

    assign int_edge = int_req && !int_req_q;
    assign is_arith = writes_reg && (wb_src == WB_ALU);
    assign needs_wb = is_load || is_store || is_arith;

    // IDLE without a read in flight only happens right after reset
    assign issue_fetch = (state == IDLE && !rd_ram_en) ||
                         (state == EXECUTE && !needs_wb) ||
                         (state == WRITEBACK);
    assign take_int = issue_fetch && int_pend;

    always_comb begin
        if (is_reti) begin
            next_pc = saved_pc;
        end else if (is_jmp || (is_jnz && !zero_flag)) begin
            next_pc = ir.imm_form.imm;
        end else begin
            next_pc = pc + `ADDR_BITS'(2);
        end
    end

    assign fetch_pc = (state == EXECUTE) ? next_pc : pc;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= IDLE;
            pc        <= '0;
            zero_flag <= 1'b0;
            int_en    <= 1'b0;
            int_pend  <= 1'b0;
            int_req_q <= 1'b0;
            rd_ram_en <= 1'b0;
            wr_ram_en <= 1'b0;
            int_ack   <= 1'b0;
        end else begin
            int_req_q <= int_req;
            rd_ram_en <= 1'b0;
            wr_ram_en <= 1'b0;
            int_ack   <= 1'b0;
            if (int_edge && int_en) begin
                int_pend <= 1'b1;
            end

            case (state)
                IDLE: begin
                    if (rd_ram_en) begin
                        state     <= FETCH_HI;
                        rd_ram_en <= 1'b1;
                    end
                end
                FETCH_HI: state <= FETCH_LO;
                FETCH_LO: begin
                    // Data read and store pulse both land in EXECUTE
                    state     <= EXECUTE;
                    rd_ram_en <= is_load;
                    wr_ram_en <= is_store;
                end
                EXECUTE: begin
                    if (is_arith) begin
                        zero_flag <= alu_zero;
                    end
                    if (is_sti || is_reti) begin
                        int_en <= 1'b1;
                    end
                    if (is_cli) begin
                        int_en   <= 1'b0;
                        int_pend <= 1'b0;
                    end
                    pc    <= next_pc;
                    state <= WRITEBACK;
                end
                // WRITEBACK leaves through the fetch issue below
                default: state <= IDLE;
            endcase

            if (issue_fetch) begin
                state     <= IDLE;
                rd_ram_en <= 1'b1;
                if (int_pend) begin
                    pc       <= `ISR_ADDRESS;
                    int_ack  <= 1'b1;
                    int_pend <= 1'b0;
                    int_en   <= 1'b0;
                end else begin
                    pc <= fetch_pc;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: rd_ram_addr <= rd_ram_addr + `ADDR_BITS'(1);
            FETCH_HI: ir[15:8] <= rd_ram_data;
            FETCH_LO: begin
                ir[7:0]     <= rd_ram_data;
                rd_ram_addr <= rd_ram_data;
                wr_ram_addr <= rd_ram_data;
                wr_ram_data <= rd_a_data;
            end
            EXECUTE: alu_res <= alu_result;
            default: ;
        endcase

        if (issue_fetch) begin
            rd_ram_addr <= take_int ? `ISR_ADDRESS : fetch_pc;
            if (take_int) begin
                saved_pc <= fetch_pc;
            end
        end
    end

    assign alu_b = b_imm ? ir.imm_form.imm : rd_b_data;

    // MOVI writes in EXECUTE, LOAD and arithmetic one cycle later
    assign reg_wr_en = writes_reg &&
                       ((state == EXECUTE && wb_src == WB_IMM) ||
                        (state == WRITEBACK && wb_src != WB_IMM));
    assign reg_wr_addr = ir.imm_form.rd;

    always_comb begin
        case (wb_src)
            WB_IMM:  reg_wr_data = ir.imm_form.imm;
            WB_LOAD: reg_wr_data = rd_ram_data;
            default: reg_wr_data = alu_res;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module register_file (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire [`REG_ADDR_BITS-1:0]   rd_a_addr,
    input  wire [`REG_ADDR_BITS-1:0]   rd_b_addr,
    input  wire                        wr_en,
    input  wire [`REG_ADDR_BITS-1:0]   wr_addr,
    input  wire [`DATA_BITS-1:0]       wr_data,
    output logic [`DATA_BITS-1:0]      rd_a_data,
    output logic [`DATA_BITS-1:0]      rd_b_data
);

    logic [`DATA_BITS-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle read of the written entry sees the old contents
    assign rd_a_data = regs[rd_a_addr];
    assign rd_b_data = regs[rd_b_addr];

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module alu
    import cpu_pkg::*;
(
    input  wire [`DATA_BITS-1:0]  a,
    input  wire [`DATA_BITS-1:0]  b,
    input  wire alu_op_e          op,
    output logic [`DATA_BITS-1:0] result,
    output logic                  zero
);

    // Wraps modulo 2**DATA_BITS, carry is not kept
    always_comb begin
        if (op == ALU_SUB) begin
            result = a - b;
        end else begin
            result = a + b;
        end
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module instr_decode
    import cpu_pkg::*;
(
    input  wire instr_word_t                ir,
    output alu_op_e                         alu_op,
    output logic                            b_imm,
    output logic                            writes_reg,
    output wb_src_e                         wb_src,
    output logic                            is_load,
    output logic                            is_store,
    output logic                            is_jnz,
    output logic                            is_jmp,
    output logic                            is_cli,
    output logic                            is_sti,
    output logic                            is_reti,
    output logic [`REG_ADDR_BITS-1:0]       rd_a_addr,
    output logic [`REG_ADDR_BITS-1:0]       rd_b_addr
);

    always_comb begin
        alu_op     = ALU_ADD;
        b_imm      = 1'b0;
        writes_reg = 1'b0;
        wb_src     = WB_ALU;
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_jnz     = 1'b0;
        is_jmp     = 1'b0;
        is_cli     = 1'b0;
        is_sti     = 1'b0;
        is_reti    = 1'b0;
        // Immediate forms and STORE read rd on port a
        rd_a_addr  = ir.imm_form.rd;
        rd_b_addr  = ir.reg_form.rs_b;

        case (ir.imm_form.opcode)
            MOVI: begin
                writes_reg = 1'b1;
                wb_src     = WB_IMM;
            end
            LOAD: begin
                writes_reg = 1'b1;
                wb_src     = WB_LOAD;
                is_load    = 1'b1;
            end
            STORE: is_store = 1'b1;
            ADD: begin
                writes_reg = 1'b1;
                rd_a_addr  = ir.reg_form.rs_a;
            end
            ADDI: begin
                writes_reg = 1'b1;
                b_imm      = 1'b1;
            end
            SUB: begin
                alu_op     = ALU_SUB;
                writes_reg = 1'b1;
                rd_a_addr  = ir.reg_form.rs_a;
            end
            SUBI: begin
                alu_op     = ALU_SUB;
                writes_reg = 1'b1;
                b_imm      = 1'b1;
            end
            JNZ:  is_jnz  = 1'b1;
            JMP:  is_jmp  = 1'b1;
            CLI:  is_cli  = 1'b1;
            STI:  is_sti  = 1'b1;
            RETI: is_reti = 1'b1;
            // NOP and every unassigned code
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/cpu_pkg.sv */
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    // Top nibble of the instruction word; unlisted codes run as NOP
    typedef enum logic [3:0] {
        MOVI  = 4'd0,
        LOAD  = 4'd2,
        STORE = 4'd3,
        ADD   = 4'd4,
        ADDI  = 4'd5,
        SUB   = 4'd6,
        SUBI  = 4'd7,
        JNZ   = 4'd8,
        JMP   = 4'd10,
        CLI   = 4'd11,
        STI   = 4'd12,
        RETI  = 4'd13,
        NOP   = 4'd15
    } opcode_e;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_IMM  = 2'd1,
        WB_LOAD = 2'd2
    } wb_src_e;

    // Immediate also serves as memory address and jump target
    typedef struct packed {
        opcode_e                   opcode;
        logic [`REG_ADDR_BITS-1:0] rd;
        logic [`DATA_BITS-1:0]     imm;
    } imm_form_t;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`REG_ADDR_BITS-1:0] rd;
        logic [`REG_ADDR_BITS-1:0] rs_a;
        logic [`REG_ADDR_BITS-1:0] rs_b;
    } reg_form_t;

    typedef union packed {
        imm_form_t imm_form;
        reg_form_t reg_form;
    } instr_word_t;

endpackage

`default_nettype wire

/* include/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Memory and datapath widths
`define ADDR_BITS 8
`define DATA_BITS 8

`define REG_COUNT 16
`define REG_ADDR_BITS $clog2(`REG_COUNT)

`define ISR_ADDRESS 8'hC0

`endif
